//--- sources.f
verilog/cfu_pkg.sv
verilog/weight_memory.sv
verilog/axi_read_dma.sv
verilog/neuron_mac.sv
verilog/cfu_command_unit.sv
verilog/cfu_top.sv
testbench/axi_read_memory.sv
testbench/tb_cfu.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_cfu -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_cfu > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

//--- testbench/tb_cfu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cfu;

  // Cycles allowed per table row before the run is stopped
  localparam int CYCLES_PER_ROW = 2000;

  // One table row; poll holds the busy status to poll through, 0 for none
  typedef struct packed {
    logic [9:0]  opcode;
    logic [31:0] in0;
    logic [31:0] in1;
    logic [7:0]  poll;
    logic [31:0] expected;
  } row_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_input_0;
  logic [31:0] cmd_input_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_data;
  // AXI read channel between DUT and memory model
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rlast;
  logic        rvalid;
  logic        rready;

  row_t rows[$];
  int   error_count = 0;
  int   cycle_count = 0;
  int   timeout_limit = 0;
  // Source and size of the most recent load command
  logic [31:0] load_src = '0;
  logic [31:0] load_bytes = '0;

  always #2 clk = ~clk;

  cfu_top DUT (
    .clk, .reset,
    .cmd_valid, .cmd_ready, .cmd_function_id, .cmd_input_0, .cmd_input_1,
    .rsp_valid, .rsp_ready, .rsp_data,
    .m_axi_araddr(araddr), .m_axi_arlen(arlen), .m_axi_arsize(arsize),
    .m_axi_arburst(arburst), .m_axi_arvalid(arvalid), .m_axi_rready(rready),
    .m_axi_arready(arready), .m_axi_rdata(rdata), .m_axi_rresp(rresp),
    .m_axi_rlast(rlast), .m_axi_rvalid(rvalid)
  );

  axi_read_memory memory (
    .clk, .reset,
    .araddr, .arlen, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("error: %s got %h expected %h", name, got, expected);
    end
  endtask

  // Byte at A holds the low 8 bits of A times 7 plus 3
  function automatic logic [7:0] pattern_byte(input logic [31:0] addr);
    logic [31:0] value;
    value = addr * 32'd7 + 32'd3;
    return value[7:0];
  endfunction

  // Bias plus signed INT8 dot product of two pattern regions
  function automatic logic [31:0] neuron_value(input logic [31:0] act_src,
      input logic [31:0] wgt_src, input int count, input logic [31:0] bias);
    int               sum;
    logic signed [7:0] a;
    logic signed [7:0] w;
    sum = int'(bias);
    for (int i = 0; i < count; i++) begin
      a = pattern_byte(act_src + i);
      w = pattern_byte(wgt_src + i);
      sum = sum + int'(a) * int'(w);
    end
    return sum;
  endfunction

  task automatic add_row(input logic [9:0] op, input logic [31:0] in0,
      input logic [31:0] in1, input logic [7:0] poll, input logic [31:0] expected);
    row_t row;
    row.opcode   = op;
    row.in0      = in0;
    row.in1      = in1;
    row.poll     = poll;
    row.expected = expected;
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [7:0] loading;
    logic [7:0] computing;
    logic [31:0] done;
    loading   = cfu_pkg::STATUS_BUSY_LOADING;
    computing = cfu_pkg::STATUS_BUSY_COMPUTING;
    done      = 32'(cfu_pkg::STATUS_DONE);
    add_row(cfu_pkg::GET_STATUS, 0, 0, 0, 32'(cfu_pkg::STATUS_IDLE));
    add_row(10'd6, 0, 0, 0, 32'hFFFF_FFFF);
    // Neuron 1, bias -100, inputs from 0x100, weights from 0x200
    add_row(cfu_pkg::SET_NEURON_CONFIG, 1, 32'(-100), 0, 0);
    add_row(cfu_pkg::LOAD_INPUT, 32'h100, 16, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, loading, done);
    add_row(cfu_pkg::LOAD_WEIGHTS, 32'h200, 16, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, loading, done);
    add_row(cfu_pkg::START_COMPUTE, 0, 0, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, computing, done);
    add_row(cfu_pkg::READ_RESULT, 0, 0, 0, neuron_value(32'h100, 32'h200, 16, 32'(-100)));
    // Neuron 0, bias 1000, weights from 0x300
    add_row(cfu_pkg::SET_NEURON_CONFIG, 0, 1000, 0, 0);
    add_row(cfu_pkg::LOAD_WEIGHTS, 32'h300, 16, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, loading, done);
    add_row(cfu_pkg::START_COMPUTE, 0, 0, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, computing, done);
    add_row(cfu_pkg::READ_RESULT, 0, 0, 0, neuron_value(32'h100, 32'h300, 16, 1000));
    // Error flags from the SLVERR region
    add_row(cfu_pkg::GET_ERROR, 0, 0, 0, 0);
    add_row(cfu_pkg::LOAD_WEIGHTS, 32'h8000, 16, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, loading, done);
    add_row(cfu_pkg::GET_ERROR, 0, 0, 0, 1);
    add_row(cfu_pkg::LOAD_INPUT, 32'h8040, 16, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, loading, done);
    add_row(cfu_pkg::GET_ERROR, 0, 0, 0, 3);
    // Clear wipes flags, result and the done state
    add_row(cfu_pkg::CLEAR, 0, 0, 0, 0);
    add_row(cfu_pkg::GET_ERROR, 0, 0, 0, 0);
    add_row(cfu_pkg::READ_RESULT, 0, 0, 0, 0);
    add_row(cfu_pkg::GET_STATUS, 0, 0, 0, 32'(cfu_pkg::STATUS_IDLE));
    add_row(10'd9, 0, 0, 0, 32'hFFFF_FFFF);
    add_row(cfu_pkg::GET_STATUS, 0, 0, 0, 32'(cfu_pkg::STATUS_IDLE));
    add_row(10'h3FF, 0, 0, 0, 32'hFFFF_FFFF);
  endtask

  // One command through the port with a random hold on the response
  task automatic run_command(input logic [9:0] op, input logic [31:0] in0,
                             input logic [31:0] in1, output logic [31:0] rsp);
    int          stall;
    logic [31:0] held;
    bit          taken;
    @(posedge clk);
    // Previous response must be gone before the next command
    check_value("rsp_valid", rsp_valid, 0);
    cmd_valid       <= 1'b1;
    cmd_function_id <= op;
    cmd_input_0     <= in0;
    cmd_input_1     <= in1;
    do begin
      @(posedge clk);
    end while (!cmd_ready);
    cmd_valid <= 1'b0;
    stall = $urandom % 3;
    rsp_ready <= (stall == 0);
    @(posedge clk);
    held  = rsp_data;
    taken = 1'b0;
    while (!taken) begin
      // Response held and stable while no new command is taken
      check_value("rsp_valid", rsp_valid, 1);
      check_value("rsp_data", rsp_data, held);
      check_value("cmd_ready", cmd_ready, 0);
      if (rsp_ready) begin
        taken = 1'b1;
        rsp_ready <= 1'b0;
      end else begin
        stall--;
        rsp_ready <= (stall == 0);
        @(posedge clk);
      end
    end
    rsp = held;
  endtask

  // Burst request of each accepted address: one INCR burst of 4-byte beats
  always @(posedge clk) begin
    if (!reset && arvalid && arready) begin
      check_value("araddr", araddr, load_src);
      check_value("arlen", {24'd0, arlen}, load_bytes / 4 - 32'd1);
      check_value("arsize", {29'd0, arsize}, 32'd2);
      check_value("arburst", {30'd0, arburst}, 32'd1);
    end
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      $display("timeout: the command table did not finish within %0d cycles", timeout_limit);
      $display("Error count: %0d", error_count);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    row_t        row;
    logic [31:0] rsp;
    void'($urandom(46396));
    reset           = 1'b1;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_input_0     = '0;
    cmd_input_1     = '0;
    rsp_ready       = 1'b0;
    build_table();
    timeout_limit = CYCLES_PER_ROW * rows.size();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    foreach (rows[r]) begin
      row = rows[r];
      if (row.opcode == cfu_pkg::LOAD_WEIGHTS || row.opcode == cfu_pkg::LOAD_INPUT) begin
        load_src   = row.in0;
        load_bytes = row.in1;
      end
      run_command(row.opcode, row.in0, row.in1, rsp);
      if (row.poll != 8'd0) begin
        // First poll must still see the job running
        check_value("rsp_data", rsp, {24'd0, row.poll});
        while (rsp == {24'd0, row.poll}) begin
          run_command(row.opcode, row.in0, row.in1, rsp);
        end
      end
      check_value($sformatf("rsp_data (row %0d)", r), rsp, row.expected);
    end
    @(posedge clk);
    $display("Error count: %0d", error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/axi_read_memory.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_memory (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic [31:0] araddr,
  input  wire logic [7:0]  arlen,
  input  wire logic        arvalid,
  output logic             arready,
  output logic [31:0]      rdata,
  output logic [1:0]       rresp,
  output logic             rlast,
  output logic             rvalid,
  input  wire logic        rready
);

  // Beats at or above this address answer SLVERR
  localparam logic [31:0] ERROR_BASE  = 32'h0000_8000;
  localparam logic [1:0]  RESP_OKAY   = 2'b00;
  localparam logic [1:0]  RESP_SLVERR = 2'b10;

  logic        active;
  // Address and remaining beats of the beat on offer
  logic [31:0] beat_addr;
  logic [7:0]  beats_left;

  // Byte at A holds the low 8 bits of A times 7 plus 3
  function automatic logic [7:0] pattern_byte(input logic [31:0] addr);
    logic [31:0] value;
    value = addr * 32'd7 + 32'd3;
    return value[7:0];
  endfunction

  // Little endian word from four pattern bytes
  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return {pattern_byte(addr + 32'd3), pattern_byte(addr + 32'd2),
            pattern_byte(addr + 32'd1), pattern_byte(addr)};
  endfunction

  // Outputs are quiet before the first clock edge
  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rresp   = RESP_OKAY;
    rdata   = '0;
    active  = 1'b0;
  end

  always @(posedge clk) begin : slave
    logic [31:0] next_addr;
    logic [7:0]  next_left;
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rresp   <= RESP_OKAY;
      active  <= 1'b0;
    end else if (!active) begin
      if (arvalid && arready) begin
        // Burst starts the cycle after the address is taken
        arready    <= 1'b0;
        active     <= 1'b1;
        beat_addr  <= araddr;
        beats_left <= arlen;
      end else begin
        // Random wait before arready
        arready <= arvalid && (($urandom % 4) == 0);
      end
    end else if (rvalid && rready && rlast) begin
      rvalid <= 1'b0;
      rlast  <= 1'b0;
      active <= 1'b0;
    end else if (!rvalid || rready) begin
      next_addr = beat_addr;
      next_left = beats_left;
      // Step on to the next beat once the current one was taken
      if (rvalid) begin
        next_addr = beat_addr + 32'd4;
        next_left = beats_left - 8'd1;
      end
      beat_addr  <= next_addr;
      beats_left <= next_left;
      // Random gap between beats
      rvalid <= (($urandom % 3) != 0);
      rdata  <= pattern_word(next_addr);
      rresp  <= (next_addr >= ERROR_BASE) ? RESP_SLVERR : RESP_OKAY;
      rlast  <= (next_left == 8'd0);
    end
  end

endmodule

`default_nettype wire

//--- verilog/cfu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cfu_top #(
  parameter int WEIGHT_WORDS = 1024,
  parameter int INPUT_BYTES  = 256
) (
  input  wire logic        clk,
  input  wire logic        reset,
  // CFU command and response port
  input  wire logic        cmd_valid,
  output logic             cmd_ready,
  input  wire logic [9:0]  cmd_function_id,
  input  wire logic [31:0] cmd_input_0,
  input  wire logic [31:0] cmd_input_1,
  output logic             rsp_valid,
  input  wire logic        rsp_ready,
  output logic [31:0]      rsp_data,
  // AXI4 read master
  output logic [31:0]      m_axi_araddr,
  output logic [7:0]       m_axi_arlen,
  output logic [2:0]       m_axi_arsize,
  output logic [1:0]       m_axi_arburst,
  output logic             m_axi_arvalid,
  input  wire logic        m_axi_arready,
  input  wire logic [31:0] m_axi_rdata,
  input  wire logic [1:0]  m_axi_rresp,
  input  wire logic        m_axi_rlast,
  input  wire logic        m_axi_rvalid,
  output logic             m_axi_rready
);

  // Command unit to DMA
  cfu_pkg::fetch_req_t  fetch_req;
  logic                 fetch_start;
  logic                 dma_busy;
  logic                 dma_error;
  // DMA to both local memories
  cfu_pkg::word_write_t word_write;
  // Command unit to neuron unit
  logic                 mac_start;
  logic                 mac_clear;
  logic [15:0]          neuron_idx;
  logic [cfu_pkg::BYTE_COUNT_W-1:0] input_size;
  logic signed [31:0]   bias;
  logic                 mac_busy;
  logic signed [31:0]   mac_result;
  // Neuron unit to weight memory
  logic [15:0]          weight_rd_addr;
  logic [31:0]          weight_rd_data;

  cfu_command_unit u_command_unit (
    .clk, .reset,
    .cmd_valid, .cmd_ready, .cmd_function_id, .cmd_input_0, .cmd_input_1,
    .rsp_valid, .rsp_ready, .rsp_data,
    .fetch_req, .fetch_start, .dma_busy, .dma_error,
    .mac_start, .mac_clear, .neuron_idx, .input_size, .bias,
    .mac_busy, .mac_result
  );

  axi_read_dma u_dma (
    .clk, .reset,
    .fetch_req, .fetch_start,
    .busy(dma_busy), .error(dma_error),
    .araddr(m_axi_araddr), .arlen(m_axi_arlen), .arsize(m_axi_arsize),
    .arburst(m_axi_arburst), .arvalid(m_axi_arvalid), .arready(m_axi_arready),
    .rdata(m_axi_rdata), .rresp(m_axi_rresp), .rlast(m_axi_rlast),
    .rvalid(m_axi_rvalid), .rready(m_axi_rready),
    .word_write
  );

  weight_memory #(.WEIGHT_WORDS(WEIGHT_WORDS)) u_weight_memory (
    .clk, .word_write,
    .rd_addr(weight_rd_addr), .rd_data(weight_rd_data)
  );

  neuron_mac #(.INPUT_BYTES(INPUT_BYTES)) u_neuron_mac (
    .clk, .reset, .word_write,
    .start(mac_start), .clear(mac_clear),
    .neuron_idx, .input_size, .bias,
    .weight_rd_addr, .weight_rd_data,
    .busy(mac_busy), .result(mac_result)
  );

endmodule

`default_nettype wire

//--- verilog/cfu_command_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cfu_command_unit (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         cmd_valid,
  output logic                              cmd_ready,
  input  wire logic [9:0]                   cmd_function_id,
  input  wire logic [31:0]                  cmd_input_0,
  input  wire logic [31:0]                  cmd_input_1,
  input  wire logic                         rsp_ready,
  output logic                              rsp_valid,
  output logic [31:0]                       rsp_data,
  output cfu_pkg::fetch_req_t               fetch_req,
  output logic                              fetch_start,
  input  wire logic                         dma_busy,
  input  wire logic                         dma_error,
  output logic                              mac_start,
  output logic                              mac_clear,
  output logic [15:0]                       neuron_idx,
  output logic [cfu_pkg::BYTE_COUNT_W-1:0]  input_size,
  output logic signed [31:0]                bias,
  input  wire logic                         mac_busy,
  input  wire logic signed [31:0]           mac_result
);

  cfu_pkg::cmd_opcode_e opcode;
  cfu_pkg::status_e     status;
  logic                 accept;
  logic [1:0]           error_flags;
  // Latched on the end of any DMA or compute job
  logic                 op_done;
  logic                 dma_busy_q;
  logic                 mac_busy_q;
  // High in the cycle right after a busy flag drops
  logic                 finished;
  logic [31:0]          weight_dst;

  // One command in flight; a held response blocks the next one
  assign cmd_ready = !rsp_valid;
  assign accept = cmd_valid && cmd_ready;
  assign opcode = cfu_pkg::cmd_opcode_e'(cmd_function_id);

  assign finished = (dma_busy_q && !dma_busy) || (mac_busy_q && !mac_busy);

  // Weights of neuron n sit at n times the per-neuron byte count
  assign weight_dst = neuron_idx * cmd_input_1[15:0];

  // Start pulses count as busy so a poll right after a start never reads IDLE
  always_comb begin
    if (dma_busy || fetch_start) begin
      status = cfu_pkg::STATUS_BUSY_LOADING;
    end else if (mac_busy || mac_start) begin
      status = cfu_pkg::STATUS_BUSY_COMPUTING;
    end else if (op_done || finished) begin
      status = cfu_pkg::STATUS_DONE;
    end else begin
      status = cfu_pkg::STATUS_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid   <= 1'b0;
      fetch_start <= 1'b0;
      mac_start   <= 1'b0;
      mac_clear   <= 1'b0;
      neuron_idx  <= '0;
      input_size  <= '0;
      bias        <= '0;
      error_flags <= '0;
      op_done     <= 1'b0;
      dma_busy_q  <= 1'b0;
      mac_busy_q  <= 1'b0;
    end else begin
      // Pulses last one cycle
      fetch_start <= 1'b0;
      mac_start   <= 1'b0;
      mac_clear   <= 1'b0;
      dma_busy_q  <= dma_busy;
      mac_busy_q  <= mac_busy;

      if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;
      end

      if (accept) begin
        rsp_valid <= 1'b1;
        rsp_data  <= '0;
        op_done   <= 1'b0;
        case (opcode)
          cfu_pkg::LOAD_WEIGHTS: begin
            // A load during a running transfer is acked and dropped
            if (!dma_busy && !fetch_start) begin
              fetch_req.src_addr   <= cmd_input_0;
              fetch_req.byte_count <= cmd_input_1[15:0];
              fetch_req.dst_addr   <= weight_dst[15:0];
              fetch_req.target     <= cfu_pkg::TARGET_WEIGHTS;
              fetch_start          <= 1'b1;
            end
          end
          cfu_pkg::LOAD_INPUT: begin
            if (!dma_busy && !fetch_start) begin
              fetch_req.src_addr   <= cmd_input_0;
              fetch_req.byte_count <= cmd_input_1[15:0];
              fetch_req.dst_addr   <= '0;
              fetch_req.target     <= cfu_pkg::TARGET_INPUT;
              fetch_start          <= 1'b1;
              input_size           <= cmd_input_1[15:0];
            end
          end
          cfu_pkg::SET_NEURON_CONFIG: begin
            neuron_idx <= cmd_input_0[15:0];
            bias       <= cmd_input_1;
          end
          cfu_pkg::START_COMPUTE: begin
            mac_start <= !mac_busy;
          end
          cfu_pkg::GET_STATUS: begin
            rsp_data <= {24'd0, status};
          end
          cfu_pkg::READ_RESULT: begin
            rsp_data <= mac_result;
          end
          cfu_pkg::GET_ERROR: begin
            rsp_data <= {30'd0, error_flags};
          end
          cfu_pkg::CLEAR: begin
            error_flags <= '0;
            mac_clear   <= 1'b1;
          end
          default: begin
            rsp_data <= cfu_pkg::ERR_RESPONSE;
          end
        endcase
      end

      // Completion and errors win over a command in the same cycle
      if (finished) begin
        op_done <= 1'b1;
      end
      if (dma_error) begin
        if (fetch_req.target == cfu_pkg::TARGET_WEIGHTS) begin
          error_flags[0] <= 1'b1;
        end else begin
          error_flags[1] <= 1'b1;
        end
      end
    end
  end

  // Held response stays valid and unchanged until taken
  rsp_hold_a: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

`default_nettype wire

//--- verilog/neuron_mac.sv
`timescale 1ns/1ps
`default_nettype none

module neuron_mac #(
  parameter int INPUT_BYTES = 256
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  cfu_pkg::word_write_t              word_write,
  input  wire logic                         start,
  input  wire logic                         clear,
  input  wire logic [15:0]                  neuron_idx,
  input  wire logic [cfu_pkg::BYTE_COUNT_W-1:0] input_size,
  input  wire logic signed [31:0]           bias,
  output logic [15:0]                       weight_rd_addr,
  input  wire logic [31:0]                  weight_rd_data,
  output logic                              busy,
  output logic signed [31:0]                result
);

  localparam int ACT_WORDS = INPUT_BYTES / 4;
  localparam int ACT_AW    = $clog2(ACT_WORDS);

  // Activation buffer, four INT8 values per word
  logic [31:0]        act_mem [ACT_WORDS];
  logic [31:0]        weight_base;
  logic [31:0]        weight_byte_addr;
  // Read side of the pipeline
  logic [15:0]        rd_idx;
  logic               issue;
  // Multiply side, one cycle behind the read
  logic               p_valid;
  logic [15:0]        p_idx;
  logic [1:0]         p_sel;
  logic signed [7:0]  w_byte;
  logic signed [7:0]  a_byte;
  logic signed [15:0] product;
  logic signed [31:0] acc;

  assign issue = busy && (rd_idx < input_size);
  assign weight_byte_addr = weight_base + {16'd0, rd_idx};
  assign weight_rd_addr = weight_byte_addr[17:2];

  // Little-endian byte pick from the returned words
  assign w_byte  = weight_rd_data[{p_sel, 3'b000} +: 8];
  assign a_byte  = act_mem[p_idx[ACT_AW+1:2]][{p_idx[1:0], 3'b000} +: 8];
  assign product = w_byte * a_byte;
  assign result  = acc;

  // DMA fill and clear of the activation buffer
  always_ff @(posedge clk) begin
    if (clear) begin
      for (int i = 0; i < ACT_WORDS; i++) begin
        act_mem[i] <= '0;
      end
    end else if (word_write.valid && word_write.target == cfu_pkg::TARGET_INPUT) begin
      act_mem[word_write.addr[ACT_AW-1:0]] <= word_write.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      busy    <= 1'b0;
      p_valid <= 1'b0;
      acc     <= '0;
    end else if (start && !busy) begin
      // Accumulator starts from the bias
      busy    <= 1'b1;
      p_valid <= 1'b0;
      acc     <= bias;
    end else begin
      p_valid <= issue;
      if (p_valid) begin
        acc <= acc + 32'(product);
      end
      // Last product is added on the edge that drops busy
      if (busy && !issue) begin
        busy <= 1'b0;
      end
    end
  end

  // Index and base address need no reset, start loads them
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      rd_idx      <= '0;
      weight_base <= neuron_idx * input_size;
    end else if (issue) begin
      rd_idx <= rd_idx + 16'd1;
      p_idx  <= rd_idx;
      p_sel  <= weight_byte_addr[1:0];
    end
  end

  // Configured size must fit the activation buffer during a run
  size_fits_a: assert property (@(posedge clk) disable iff (reset)
    busy |-> input_size <= INPUT_BYTES);

endmodule

`default_nettype wire

//--- verilog/axi_read_dma.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_dma (
  input  wire logic           clk,
  input  wire logic           reset,
  input  cfu_pkg::fetch_req_t fetch_req,
  input  wire logic           fetch_start,
  output logic                busy,
  output logic                error,
  output logic [31:0]         araddr,
  output logic [7:0]          arlen,
  output logic [2:0]          arsize,
  output logic [1:0]          arburst,
  output logic                arvalid,
  input  wire logic           arready,
  input  wire logic [31:0]    rdata,
  input  wire logic [1:0]     rresp,
  input  wire logic           rlast,
  input  wire logic           rvalid,
  output logic                rready,
  output cfu_pkg::word_write_t word_write
);

  // 4-byte beats, incrementing burst
  localparam logic [2:0] SIZE_4B    = 3'b010;
  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_ADDR,
    DMA_DATA
  } dma_state_e;

  dma_state_e          state;
  cfu_pkg::fetch_req_t job;
  // Destination word address of the next beat
  logic [15:0]         word_addr;
  logic [13:0]         beats_minus_one;
  logic                beat;

  // Byte count is a whole number of words, at most 256 of them
  assign beats_minus_one = job.byte_count[15:2] - 14'd1;

  assign araddr  = job.src_addr;
  assign arlen   = beats_minus_one[7:0];
  assign arsize  = SIZE_4B;
  assign arburst = BURST_INCR;
  assign arvalid = (state == DMA_ADDR);
  assign rready  = (state == DMA_DATA);
  assign busy    = (state != DMA_IDLE);

  assign beat = rvalid && rready;
  // Error beats are still written, the flag keeps track of them
  assign error = beat && (rresp != 2'b00);

  assign word_write.valid  = beat;
  assign word_write.target = job.target;
  assign word_write.addr   = word_addr;
  assign word_write.data   = rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DMA_IDLE;
    end else begin
      case (state)
        DMA_IDLE: begin
          if (fetch_start) begin
            state <= DMA_ADDR;
          end
        end
        DMA_ADDR: begin
          if (arready) begin
            state <= DMA_DATA;
          end
        end
        DMA_DATA: begin
          if (beat && rlast) begin
            state <= DMA_IDLE;
          end
        end
        default: state <= DMA_IDLE;
      endcase
    end
  end

  // Job and address counter carry no reset
  always_ff @(posedge clk) begin
    if (state == DMA_IDLE && fetch_start) begin
      job       <= fetch_req;
      word_addr <= {2'b00, fetch_req.dst_addr[15:2]};
    end else if (beat) begin
      word_addr <= word_addr + 16'd1;
    end
  end

  // Address phase must hold still until the slave takes it
  ar_stable_a: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

`default_nettype wire

//--- verilog/weight_memory.sv
`timescale 1ns/1ps
`default_nettype none

module weight_memory #(
  parameter int WEIGHT_WORDS = 1024
) (
  input  wire logic            clk,
  input  cfu_pkg::word_write_t word_write,
  input  wire logic [15:0]     rd_addr,
  output logic [31:0]          rd_data
);

  localparam int ADDR_W = $clog2(WEIGHT_WORDS);

  // Four INT8 weights per word, lowest address in the low byte
  logic [31:0] mem [WEIGHT_WORDS];
  logic        wr_en;

  // Only words tagged for the weights land here
  assign wr_en = word_write.valid && (word_write.target == cfu_pkg::TARGET_WEIGHTS);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[word_write.addr[ADDR_W-1:0]] <= word_write.data;
    end
    // Read data one cycle after the address
    rd_data <= mem[rd_addr[ADDR_W-1:0]];
  end

endmodule

`default_nettype wire

//--- verilog/cfu_pkg.sv
`default_nettype none

package cfu_pkg;

  // Width of byte counts, transfer sizes and buffer sizes
  parameter int BYTE_COUNT_W = 16;

  // Answer for any function ID outside the command set
  parameter logic [31:0] ERR_RESPONSE = 32'hFFFF_FFFF;

  // CFU function IDs
  // Codes 6 and 9 are not decoded and get ERR_RESPONSE
  typedef enum logic [9:0] {
    LOAD_WEIGHTS      = 10'd0,
    LOAD_INPUT        = 10'd1,
    SET_NEURON_CONFIG = 10'd2,
    START_COMPUTE     = 10'd3,
    GET_STATUS        = 10'd4,
    READ_RESULT       = 10'd5,
    GET_ERROR         = 10'd7,
    CLEAR             = 10'd8
  } cmd_opcode_e;

  // Value returned by GET_STATUS in the low byte
  typedef enum logic [7:0] {
    STATUS_IDLE           = 8'd0,
    STATUS_BUSY_LOADING   = 8'd1,
    STATUS_BUSY_COMPUTING = 8'd2,
    STATUS_DONE           = 8'd3
  } status_e;

  // Where a fetched word ends up
  typedef enum logic {
    TARGET_WEIGHTS = 1'b0,
    TARGET_INPUT   = 1'b1
  } dma_target_e;

  // One DMA job, 65 bits
  typedef struct packed {
    logic [31:0]             src_addr;
    logic [BYTE_COUNT_W-1:0] byte_count;
    // Byte address inside the destination memory
    logic [15:0]             dst_addr;
    dma_target_e             target;
  } fetch_req_t;

  // One word from the DMA into a local memory, 50 bits
  typedef struct packed {
    logic        valid;
    dma_target_e target;
    // Word address, already divided by 4
    logic [15:0] addr;
    logic [31:0] data;
  } word_write_t;

endpackage

`default_nettype wire
